/* hdl/udp_echo_pkg.sv */
/* Shared widths, address constants and FSM states for the UDP echo responder.
   The local IP and echo port are fixed at build time. */
package udp_echo_pkg;

    // Widths that carry a meaning
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] port_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [7:0]  ttl_t;

    // Local address 192.168.1.128
    localparam ip_addr_t LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128};

    // Datagrams to this port are echoed, all others dropped
    localparam port_t ECHO_PORT = 16'd1234;

    localparam ttl_t REPLY_TTL = 8'd64;

    // Payload FIFO sizing, FIFO_ADDR_W must be log2 of FIFO_DEPTH
    localparam integer FIFO_DEPTH  = 2048;
    localparam integer FIFO_ADDR_W = 11;

    typedef enum logic [1:0] {
        IDLE,
        REPLY,
        PASS,
        DROP
    } echo_state_t;

endpackage

/* hdl/echo_frame_fsm.sv */
/* Accepts one UDP header at a time and decides echo or drop from its port.
   Every datagram must end its payload with a tlast beat, or the FSM hangs. */
`timescale 1ns/1ps

module echo_frame_fsm import udp_echo_pkg::*; (
    input  logic  clk_125mhz,
    input  logic  rst_125mhz,

    // Receive header
    input  logic  rx_hdr_valid,
    output logic  rx_hdr_ready,
    input  port_t rx_dst_port,

    // Receive payload control
    input  logic  rx_tvalid,
    input  logic  rx_tlast,
    output logic  rx_tready,

    // Reply header control
    output logic  hdr_load,
    output logic  tx_hdr_valid,
    input  logic  tx_hdr_ready,

    // Payload buffer write side
    output logic  buf_wr_valid,
    input  logic  buf_wr_ready
);

    echo_state_t state;
    echo_state_t state_next;

    logic port_match;
    logic hdr_accept;
    logic rx_last_beat;

    assign port_match = (rx_dst_port == ECHO_PORT);

    // New headers only while no frame is in progress
    assign rx_hdr_ready = (state == IDLE);
    assign hdr_accept   = rx_hdr_valid && rx_hdr_ready;
    assign hdr_load     = hdr_accept && port_match;

    // Reply header is offered from the cycle after acceptance
    assign tx_hdr_valid = (state == REPLY);

    // PASS feeds the FIFO, DROP sinks everything
    assign buf_wr_valid = rx_tvalid && (state == PASS);
    assign rx_tready    = ((state == PASS) && buf_wr_ready) || (state == DROP);
    assign rx_last_beat = rx_tvalid && rx_tready && rx_tlast;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (hdr_accept) begin
                    state_next = port_match ? REPLY : DROP;
                end
            end
            REPLY: begin
                if (tx_hdr_ready) begin
                    state_next = PASS;
                end
            end
            PASS, DROP: begin
                if (rx_last_beat) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Reply header must stay offered until the stack takes it
    a_hdr_held: assert property (
        @(posedge clk_125mhz) disable iff (rst_125mhz)
        (tx_hdr_valid && !tx_hdr_ready) |=> tx_hdr_valid
    );

endmodule

/* hdl/echo_reply_header.sv */
/* Holds the reply header built from the last echoed datagram.
   Fields are loaded only on hdr_load and are stable while the reply waits. */
`timescale 1ns/1ps

module echo_reply_header import udp_echo_pkg::*; (
    input  logic     clk_125mhz,
    input  logic     rst_125mhz,

    input  logic     hdr_load,
    input  ip_addr_t rx_src_ip,
    input  port_t    rx_src_port,
    input  port_t    rx_dst_port,
    input  port_t    rx_udp_length,

    output ip_addr_t tx_src_ip,
    output ip_addr_t tx_dst_ip,
    output port_t    tx_src_port,
    output port_t    tx_dst_port,
    output port_t    tx_udp_length,
    output ttl_t     tx_ttl,
    output logic [5:0] tx_dscp,
    output logic [1:0] tx_ecn,
    output port_t    tx_checksum
);

    ip_addr_t dst_ip_reg;
    port_t    src_port_reg;
    port_t    dst_port_reg;
    port_t    length_reg;

    // Swap ports and answer the sender
    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            dst_ip_reg   <= '0;
            src_port_reg <= '0;
            dst_port_reg <= '0;
            length_reg   <= '0;
        end else if (hdr_load) begin
            dst_ip_reg   <= rx_src_ip;
            src_port_reg <= rx_dst_port;
            dst_port_reg <= rx_src_port;
            length_reg   <= rx_udp_length;
        end
    end

    assign tx_dst_ip     = dst_ip_reg;
    assign tx_src_port   = src_port_reg;
    assign tx_dst_port   = dst_port_reg;
    assign tx_udp_length = length_reg;

    // Fixed fields; zero checksum means none for UDP over IPv4
    assign tx_src_ip   = LOCAL_IP;
    assign tx_ttl      = REPLY_TTL;
    assign tx_dscp     = '0;
    assign tx_ecn      = '0;
    assign tx_checksum = '0;

endmodule

/* hdl/payload_buffer.sv */
/* Byte FIFO for echoed payload, with tlast and tuser stored per beat.
   Holds FIFO_DEPTH beats in memory plus one in the output register. */
`timescale 1ns/1ps

module payload_buffer import udp_echo_pkg::*; (
    input  logic  clk_125mhz,
    input  logic  rst_125mhz,

    // Write side
    input  logic  buf_wr_valid,
    output logic  buf_wr_ready,
    input  byte_t rx_tdata,
    input  logic  rx_tlast,
    input  logic  rx_tuser,

    // Transmit payload
    output byte_t tx_tdata,
    output logic  tx_tvalid,
    input  logic  tx_tready,
    output logic  tx_tlast,
    output logic  tx_tuser,

    output byte_t led
);

    // Entry is {tuser, tlast, data}
    logic [$bits(byte_t)+1:0] mem [0:FIFO_DEPTH-1];

    logic [FIFO_ADDR_W:0] wr_ptr;
    logic [FIFO_ADDR_W:0] rd_ptr;
    logic [FIFO_ADDR_W:0] fill;
    logic full;
    logic empty;
    logic wr_en;
    logic rd_en;
    logic first_beat;

    assign fill  = wr_ptr - rd_ptr;
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[FIFO_ADDR_W] != rd_ptr[FIFO_ADDR_W]) &&
                   (wr_ptr[FIFO_ADDR_W-1:0] == rd_ptr[FIFO_ADDR_W-1:0]);

    assign buf_wr_ready = !full;
    assign wr_en = buf_wr_valid && !full;

    // Refill the output register when it is free or being taken
    assign rd_en = !empty && (!tx_tvalid || tx_tready);

    always_ff @(posedge clk_125mhz) begin
        if (wr_en) begin
            mem[wr_ptr[FIFO_ADDR_W-1:0]] <= {rx_tuser, rx_tlast, rx_tdata};
        end
        if (rd_en) begin
            {tx_tuser, tx_tlast, tx_tdata} <= mem[rd_ptr[FIFO_ADDR_W-1:0]];
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            tx_tvalid <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
                tx_tvalid <= 1'b1;
            end else if (tx_tready) begin
                tx_tvalid <= 1'b0;
            end
        end
    end

    // First byte of each transmitted frame goes to the LEDs
    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            led        <= '0;
            first_beat <= 1'b1;
        end else if (tx_tvalid && tx_tready) begin
            if (first_beat) begin
                led <= tx_tdata;
            end
            first_beat <= tx_tlast;
        end
    end

    // Occupancy never goes past the memory size
    a_no_overflow: assert property (
        @(posedge clk_125mhz) disable iff (rst_125mhz)
        fill <= FIFO_DEPTH
    );

    // Output only shows beats that were written earlier
    a_no_underflow: assert property (
        @(posedge clk_125mhz) disable iff (rst_125mhz)
        (empty && !tx_tvalid) |=> !tx_tvalid
    );

endmodule

/* hdl/udp_echo_top.sv */
/* UDP echo responder on the header and payload streams of a UDP/IP stack.
   Only port 1234 is echoed; the reply carries a zero UDP checksum. */
`timescale 1ns/1ps

module udp_echo_top import udp_echo_pkg::*; (
    input  logic       clk_125mhz,
    input  logic       rst_125mhz,

    // Receive UDP header
    input  logic       rx_hdr_valid,
    output logic       rx_hdr_ready,
    input  ip_addr_t   rx_src_ip,
    input  port_t      rx_src_port,
    input  port_t      rx_dst_port,
    input  port_t      rx_udp_length,

    // Receive UDP payload
    input  byte_t      rx_tdata,
    input  logic       rx_tvalid,
    output logic       rx_tready,
    input  logic       rx_tlast,
    input  logic       rx_tuser,

    // Transmit UDP header
    output logic       tx_hdr_valid,
    input  logic       tx_hdr_ready,
    output ip_addr_t   tx_src_ip,
    output ip_addr_t   tx_dst_ip,
    output port_t      tx_src_port,
    output port_t      tx_dst_port,
    output port_t      tx_udp_length,
    output ttl_t       tx_ttl,
    output logic [5:0] tx_dscp,
    output logic [1:0] tx_ecn,
    output port_t      tx_checksum,

    // Transmit UDP payload
    output byte_t      tx_tdata,
    output logic       tx_tvalid,
    input  logic       tx_tready,
    output logic       tx_tlast,
    output logic       tx_tuser,

    output byte_t      led
);

    logic hdr_load;
    logic buf_wr_valid;
    logic buf_wr_ready;

    echo_frame_fsm u_fsm (
        .clk_125mhz   (clk_125mhz),
        .rst_125mhz   (rst_125mhz),
        .rx_hdr_valid (rx_hdr_valid),
        .rx_hdr_ready (rx_hdr_ready),
        .rx_dst_port  (rx_dst_port),
        .rx_tvalid    (rx_tvalid),
        .rx_tlast     (rx_tlast),
        .rx_tready    (rx_tready),
        .hdr_load     (hdr_load),
        .tx_hdr_valid (tx_hdr_valid),
        .tx_hdr_ready (tx_hdr_ready),
        .buf_wr_valid (buf_wr_valid),
        .buf_wr_ready (buf_wr_ready)
    );

    echo_reply_header u_header (
        .clk_125mhz    (clk_125mhz),
        .rst_125mhz    (rst_125mhz),
        .hdr_load      (hdr_load),
        .rx_src_ip     (rx_src_ip),
        .rx_src_port   (rx_src_port),
        .rx_dst_port   (rx_dst_port),
        .rx_udp_length (rx_udp_length),
        .tx_src_ip     (tx_src_ip),
        .tx_dst_ip     (tx_dst_ip),
        .tx_src_port   (tx_src_port),
        .tx_dst_port   (tx_dst_port),
        .tx_udp_length (tx_udp_length),
        .tx_ttl        (tx_ttl),
        .tx_dscp       (tx_dscp),
        .tx_ecn        (tx_ecn),
        .tx_checksum   (tx_checksum)
    );

    payload_buffer u_buffer (
        .clk_125mhz   (clk_125mhz),
        .rst_125mhz   (rst_125mhz),
        .buf_wr_valid (buf_wr_valid),
        .buf_wr_ready (buf_wr_ready),
        .rx_tdata     (rx_tdata),
        .rx_tlast     (rx_tlast),
        .rx_tuser     (rx_tuser),
        .tx_tdata     (tx_tdata),
        .tx_tvalid    (tx_tvalid),
        .tx_tready    (tx_tready),
        .tx_tlast     (tx_tlast),
        .tx_tuser     (tx_tuser),
        .led          (led)
    );

endmodule

/* test/echo_checker.sv */
/* Watches the DUT ports at the falling edge and compares them with queued expectations.
   Expectations must be queued before the matching input is driven. */
`timescale 1ns/1ps

module echo_checker import udp_echo_pkg::*; #(
    parameter int CYCLE_LIMIT = 1000
) (
    input  logic       clk_125mhz,
    input  logic       rst_125mhz,
    input  logic       rx_hdr_ready,
    input  logic       rx_tready,
    input  logic       tx_hdr_valid,
    input  logic       tx_hdr_ready,
    input  ip_addr_t   tx_src_ip,
    input  ip_addr_t   tx_dst_ip,
    input  port_t      tx_src_port,
    input  port_t      tx_dst_port,
    input  port_t      tx_udp_length,
    input  ttl_t       tx_ttl,
    input  logic [5:0] tx_dscp,
    input  logic [1:0] tx_ecn,
    input  port_t      tx_checksum,
    input  byte_t      tx_tdata,
    input  logic       tx_tvalid,
    input  logic       tx_tready,
    input  logic       tx_tlast,
    input  logic       tx_tuser,
    input  byte_t      led,
    output logic       timed_out
);

    // Header entry matches the reference layout, beat entry is {tuser, tlast, data}
    logic [143:0] exp_hdr_q [$];
    logic [9:0]   exp_beat_q [$];

    string test_name = "none";
    int    test_errors = 0;
    int    error_count = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    cycles = 0;
    logic  in_frame = 1'b0;
    logic  led_pending = 1'b0;
    byte_t first_byte = '0;
    byte_t led_expected = '0;

    task automatic check_field(input string field, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        if (act_val !== exp_val) begin
            error_count++;
            test_errors++;
            $display("[ERROR] %s: %s expected 0x%0h, actual 0x%0h",
                     test_name, field, exp_val, act_val);
        end
    endtask

    task automatic report_problem(input string what);
        error_count++;
        test_errors++;
        $display("%s: %s", test_name, what);
    endtask

    task automatic expect_header(input logic [143:0] hdr);
        exp_hdr_q.push_back(hdr);
    endtask

    task automatic expect_beat(input logic user, input logic last, input byte_t data);
        exp_beat_q.push_back({user, last, data});
    endtask

    function automatic int outstanding();
        return exp_hdr_q.size() + exp_beat_q.size() + int'(led_pending);
    endfunction

    function automatic bit run_ok();
        return (error_count == 0) && (tests_failed == 0);
    endfunction

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (outstanding() != 0) begin
            report_problem($sformatf("%0d expected items never came out", outstanding()));
        end
        tests_run++;
        if (test_errors == 0) begin
            $display("Test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", test_name, test_errors);
        end
    endtask

    task automatic check_reset_state();
        start_test("reset_state");
        check_field("rx_hdr_ready", 32'd1, 32'(rx_hdr_ready));
        check_field("rx_tready", 32'd0, 32'(rx_tready));
        check_field("tx_hdr_valid", 32'd0, 32'(tx_hdr_valid));
        check_field("tx_tvalid", 32'd0, 32'(tx_tvalid));
        check_field("led", 32'd0, 32'(led));
        end_test();
    endtask

    task automatic report_counts();
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
    endtask

    task automatic compare_header(input logic [143:0] exp_hdr);
        check_field("tx_src_ip", exp_hdr[143:112], tx_src_ip);
        check_field("tx_dst_ip", exp_hdr[111:80], tx_dst_ip);
        check_field("tx_src_port", 32'(exp_hdr[79:64]), 32'(tx_src_port));
        check_field("tx_dst_port", 32'(exp_hdr[63:48]), 32'(tx_dst_port));
        check_field("tx_udp_length", 32'(exp_hdr[47:32]), 32'(tx_udp_length));
        check_field("tx_ttl", 32'(exp_hdr[31:24]), 32'(tx_ttl));
        check_field("tx_dscp", 32'(exp_hdr[23:18]), 32'(tx_dscp));
        check_field("tx_ecn", 32'(exp_hdr[17:16]), 32'(tx_ecn));
        check_field("tx_checksum", 32'(exp_hdr[15:0]), 32'(tx_checksum));
    endtask

    task automatic compare_beat(input logic [9:0] exp_beat);
        check_field("tx_tdata", 32'(exp_beat[7:0]), 32'(tx_tdata));
        check_field("tx_tlast", 32'(exp_beat[8]), 32'(tx_tlast));
        check_field("tx_tuser", 32'(exp_beat[9]), 32'(tx_tuser));
        if (!in_frame) begin
            first_byte = exp_beat[7:0];
            in_frame   = 1'b1;
        end
        // led is due on the cycle after the last beat
        if (exp_beat[8]) begin
            in_frame     = 1'b0;
            led_expected = first_byte;
            led_pending  = 1'b1;
        end
    endtask

    always @(negedge clk_125mhz) begin
        if (!rst_125mhz) begin
            if (led_pending) begin
                check_field("led", 32'(led_expected), 32'(led));
                led_pending = 1'b0;
            end
            if (tx_hdr_valid && tx_hdr_ready) begin
                if (exp_hdr_q.size() == 0) begin
                    report_problem("reply header sent when none was expected");
                end else begin
                    compare_header(exp_hdr_q.pop_front());
                end
            end
            if (tx_tvalid && tx_tready) begin
                if (exp_beat_q.size() == 0) begin
                    report_problem("payload byte sent when none was expected");
                end else begin
                    compare_beat(exp_beat_q.pop_front());
                end
            end
        end
    end

    always @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            cycles    <= 0;
            timed_out <= 1'b0;
        end else begin
            cycles <= cycles + 1;
            if (cycles == CYCLE_LIMIT && !timed_out) begin
                $display("Timeout: run did not complete within %0d cycles", CYCLE_LIMIT);
                timed_out <= 1'b1;
            end
        end
    end

endmodule

/* test/tb_udp_echo.sv */
/* Testbench for the UDP echo responder, drives headers and payload on the rx streams.
   Checking lives in echo_checker, which gets its expectations from here. */
`timescale 1ns/1ps

module tb_udp_echo import udp_echo_pkg::*; ();

    localparam int LEN_BASIC      = 16;
    localparam int LEN_DROP       = 20;
    localparam int LEN_AFTER_DROP = 8;
    localparam int BURST_FRAMES   = 5;

    // Responder address, echoed port and reply TTL
    localparam ip_addr_t REPLY_SRC_IP  = 32'hC0A8_0180;
    localparam port_t    ECHO_DST_PORT = 16'd1234;
    localparam ttl_t     REPLY_HOPS    = 8'd64;

    function automatic int burst_len(input int idx);
        case (idx)
            0: return 12;
            1: return 1;
            2: return 30;
            3: return 7;
            default: return 25;
        endcase
    endfunction

    localparam int TOTAL_LEN = LEN_BASIC + LEN_DROP + LEN_AFTER_DROP + burst_len(0) +
                               burst_len(1) + burst_len(2) + burst_len(3) + burst_len(4);

    logic clk_125mhz;
    logic rst_125mhz;
    logic rx_hdr_valid, rx_hdr_ready;
    ip_addr_t rx_src_ip;
    port_t rx_src_port, rx_dst_port, rx_udp_length;
    byte_t rx_tdata;
    logic rx_tvalid, rx_tready, rx_tlast, rx_tuser;
    logic tx_hdr_valid, tx_hdr_ready;
    ip_addr_t tx_src_ip, tx_dst_ip;
    port_t tx_src_port, tx_dst_port, tx_udp_length, tx_checksum;
    ttl_t tx_ttl;
    logic [5:0] tx_dscp;
    logic [1:0] tx_ecn;
    byte_t tx_tdata;
    logic tx_tvalid, tx_tready, tx_tlast, tx_tuser;
    byte_t led;
    logic timed_out;
    logic random_ready = 1'b0;

    udp_echo_top dut (.*);

    echo_checker #(.CYCLE_LIMIT(10 * TOTAL_LEN + 200)) chk (.*);

    initial begin
        clk_125mhz = 1'b0;
        forever #4 clk_125mhz = ~clk_125mhz;
    end

    // Reply rule: ports swapped, sent back to the sender from the local address
    function automatic logic [143:0] expected_reply(input ip_addr_t src_ip,
            input port_t src_port, input port_t dst_port, input port_t len);
        return {REPLY_SRC_IP, src_ip, dst_port, src_port, len, REPLY_HOPS, 6'd0, 2'd0, 16'd0};
    endfunction

    // Called right after a rising edge, returns right after the last accepted beat
    task automatic send_frame(input ip_addr_t src_ip, input port_t src_port,
                              input port_t dst_port, input int len);
        byte_t data;
        logic  user;
        logic  last;
        if (dst_port == ECHO_DST_PORT) begin
            chk.expect_header(expected_reply(src_ip, src_port, dst_port, port_t'(len + 8)));
        end
        rx_hdr_valid  <= 1'b1;
        rx_src_ip     <= src_ip;
        rx_src_port   <= src_port;
        rx_dst_port   <= dst_port;
        rx_udp_length <= port_t'(len + 8);
        @(negedge clk_125mhz);
        while (!rx_hdr_ready) @(negedge clk_125mhz);
        @(posedge clk_125mhz);
        rx_hdr_valid <= 1'b0;
        for (int i = 0; i < len; i++) begin
            data = byte_t'($urandom_range(0, 255));
            user = ($urandom_range(0, 3) == 0);
            last = (i == len - 1);
            if (dst_port == ECHO_DST_PORT) begin
                chk.expect_beat(user, last, data);
            end
            rx_tvalid <= 1'b1;
            rx_tdata  <= data;
            rx_tlast  <= last;
            rx_tuser  <= user;
            @(negedge clk_125mhz);
            while (!rx_tready) @(negedge clk_125mhz);
            @(posedge clk_125mhz);
        end
        rx_tvalid <= 1'b0;
        rx_tlast  <= 1'b0;
        rx_tuser  <= 1'b0;
    endtask

    task automatic wait_drained();
        do @(posedge clk_125mhz); while (chk.outstanding() != 0);
    endtask

    task finish_run();
        chk.report_counts();
        if (timed_out !== 1'b1 && chk.run_ok()) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    // Sink side ready, random during the burst test
    initial begin
        tx_hdr_ready = 1'b0;
        tx_tready    = 1'b0;
        forever begin
            @(posedge clk_125mhz);
            if (random_ready) begin
                tx_hdr_ready <= ($urandom_range(0, 1) == 1);
                tx_tready    <= ($urandom_range(0, 2) != 0);
            end else begin
                tx_hdr_ready <= 1'b1;
                tx_tready    <= 1'b1;
            end
        end
    end

    initial begin
        wait (timed_out === 1'b1);
        finish_run();
    end

    initial begin
        void'($urandom(41));
        rst_125mhz    = 1'b1;
        rx_hdr_valid  = 1'b0;
        rx_src_ip     = '0;
        rx_src_port   = '0;
        rx_dst_port   = '0;
        rx_udp_length = '0;
        rx_tdata      = '0;
        rx_tvalid     = 1'b0;
        rx_tlast      = 1'b0;
        rx_tuser      = 1'b0;
        repeat (2) @(posedge clk_125mhz);
        rst_125mhz <= 1'b0;
        @(negedge clk_125mhz);
        chk.check_reset_state();
        @(posedge clk_125mhz);

        chk.start_test("basic_echo");
        send_frame(32'hC0A8_0105, 16'd40000, ECHO_DST_PORT, LEN_BASIC);
        wait_drained();
        chk.end_test();

        chk.start_test("drop_other_port");
        send_frame(32'hC0A8_0106, 16'd40001, 16'd5000, LEN_DROP);
        // A wrongly buffered byte would reach tx one cycle after its write
        repeat (2) @(posedge clk_125mhz);
        chk.end_test();

        chk.start_test("echo_after_drop");
        send_frame(32'hC0A8_0107, 16'd40002, ECHO_DST_PORT, LEN_AFTER_DROP);
        wait_drained();
        chk.end_test();

        chk.start_test("burst_backpressure");
        random_ready <= 1'b1;
        for (int i = 0; i < BURST_FRAMES; i++) begin
            send_frame(ip_addr_t'($urandom), port_t'($urandom_range(1024, 65535)),
                       ECHO_DST_PORT, burst_len(i));
        end
        wait_drained();
        random_ready <= 1'b0;
        chk.end_test();

        finish_run();
    end

endmodule

/* src.f */
hdl/udp_echo_pkg.sv
hdl/echo_frame_fsm.sv
hdl/echo_reply_header.sv
hdl/payload_buffer.sv
hdl/udp_echo_top.sv
test/echo_checker.sv
test/tb_udp_echo.sv

/* Makefile */
SIM := obj_dir/sim

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): src.f hdl/*.sv test/*.sv
	verilator --binary --timing --assert --top-module tb_udp_echo -f src.f -o sim

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
